/* pipeline_cpu.f */
+incdir+logic
logic/cpu_pkg.sv
logic/reg_file.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/hazard_unit.sv
logic/mem_wb_stage.sv
logic/pipeline_cpu.sv
test/pipeline_cpu_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the pipeline_cpu testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary -f pipeline_cpu.f --top-module pipeline_cpu_tb -o pipeline_cpu_sim
./obj_dir/pipeline_cpu_sim | tee sim.log

if grep -q "FAIL: see errors above" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation finished without errors"

/* test/pipeline_cpu_tb.sv */
/*
 * Testbench for the pipelined processor core
 * Models both memories, builds directed programs and compares the stores
 * against an instruction-level model
 */
`timescale 1ns/100ps
`include "cpu_params.svh"

module pipeline_cpu_tb import cpu_pkg::*; ();

    logic  clock;
    logic  rst_n;
    word_t address_imem;
    word_t q_imem;
    word_t address_dmem;
    word_t data;
    logic  wren;
    word_t q_dmem;

    word_t prog [256];
    word_t dmem [256];
    int    prog_len;
    word_t st_addr [$];
    word_t st_data [$];
    word_t exp_addr [$];
    word_t exp_data [$];
    word_t lfsr_state = 32'hf797_b2a4;
    int    mismatches = 0;
    int    timeouts = 0;

    localparam word_t MARK = 32'h0000_0bad;

    pipeline_cpu pipeline_cpu_inst (
        .clock        (clock),
        .rst_n        (rst_n),
        .address_imem (address_imem),
        .q_imem       (q_imem),
        .address_dmem (address_dmem),
        .data         (data),
        .wren         (wren),
        .q_dmem       (q_dmem)
    );

    // Both memories answer in the same cycle
    assign q_imem = prog[address_imem[7:0]];
    assign q_dmem = dmem[address_dmem[7:0]];

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    always @(posedge clock) begin
        if (wren) begin
            st_addr.push_back(address_dmem);
            st_data.push_back(data);
            dmem[address_dmem[7:0]] <= data;
        end
    end

    function automatic word_t fill_word(input int i);
        return word_t'(i) * 32'h9e37_79b1 + 32'h1357_2468;
    endfunction

    function automatic word_t lfsr_next(input word_t s);
        return s[0] ? ((s >> 1) ^ 32'ha300_0000) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic word_t rand_bits(input int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    function automatic word_t enc_r(input alu_op_e alu, input int rd, input int rs,
                                    input int rt, input int shamt);
        return {OP_RTYPE, rd[4:0], rs[4:0], rt[4:0], shamt[4:0], alu, 2'b00};
    endfunction

    function automatic word_t enc_i(input opcode_e op, input int rd, input int rs, input int imm);
        return {op, rd[4:0], rs[4:0], imm[`CPU_IMM_W-1:0]};
    endfunction

    function automatic word_t enc_j(input int target);
        return {OP_J, target[`CPU_TARGET_W-1:0]};
    endfunction

    task automatic new_program();
        for (int i = 0; i < 256; i++) begin
            prog[i] = `CPU_NOP;
        end
        prog_len = 0;
    endtask

    task automatic emit(input word_t ir);
        prog[prog_len[7:0]] = ir;
        prog_len++;
    endtask

    // Instruction-level model; stops at the jump to itself
    task automatic run_model();
        word_t regs [32];
        word_t mem [256];
        word_t ir, a, b, rt_val, imm, addr, wval, pc, pc_next;
        logic  wr, done;
        int    steps;
        exp_addr.delete();
        exp_data.delete();
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            mem[i] = fill_word(i);
        end
        pc = '0;
        done = 1'b0;
        steps = 0;
        while (!done && steps < 4000) begin
            ir = prog[pc[7:0]];
            a = regs[ir[`CPU_RS_LSB +: 5]];
            b = regs[ir[`CPU_RD_LSB +: 5]];
            rt_val = regs[ir[`CPU_RT_LSB +: 5]];
            imm = {{(`CPU_XLEN - `CPU_IMM_W){ir[`CPU_IMM_W-1]}}, ir[`CPU_IMM_W-1:0]};
            addr = a + imm;
            pc_next = pc + 32'd1;
            wr = 1'b0;
            wval = '0;
            steps++;
            case (ir[`CPU_OPCODE_MSB:`CPU_OPCODE_LSB])
                OP_RTYPE: begin
                    wr = 1'b1;
                    case (ir[`CPU_ALUOP_LSB +: 5])
                        ALU_ADD: wval = a + rt_val;
                        ALU_SUB: wval = a - rt_val;
                        ALU_AND: wval = a & rt_val;
                        ALU_OR:  wval = a | rt_val;
                        ALU_SLL: wval = a << ir[`CPU_SHAMT_LSB +: 5];
                        ALU_SRA: wval = word_t'($signed(a) >>> ir[`CPU_SHAMT_LSB +: 5]);
                        default: wval = '0;
                    endcase
                end
                OP_ADDI: begin
                    wr = 1'b1;
                    wval = addr;
                end
                OP_LW: begin
                    wr = 1'b1;
                    wval = mem[addr[7:0]];
                end
                OP_SW: begin
                    mem[addr[7:0]] = b;
                    exp_addr.push_back(addr);
                    exp_data.push_back(b);
                end
                OP_BNE: if (b != a) pc_next = pc + 32'd1 + imm;
                OP_BLT: if ($signed(b) < $signed(a)) pc_next = pc + 32'd1 + imm;
                OP_J: begin
                    pc_next = {5'b0, ir[`CPU_TARGET_W-1:0]};
                    done = (pc_next == pc);
                end
                default: wr = 1'b0;
            endcase
            if (wr && ir[`CPU_RD_LSB +: 5] != 5'd0) begin
                regs[ir[`CPU_RD_LSB +: 5]] = wval;
            end
            pc = pc_next;
        end
    endtask

    // Outputs must stay quiet while reset is held
    task automatic apply_reset();
        rst_n = 1'b0;
        st_addr.delete();
        st_data.delete();
        for (int i = 0; i < 256; i++) begin
            dmem[i] <= fill_word(i);
        end
        repeat (5) begin
            @(negedge clock);
            if (wren !== 1'b0 || address_imem !== '0) begin
                mismatches++;
                $display("mismatch at %0t: in reset wren=%b address_imem=%h",
                         $time, wren, address_imem);
            end
        end
        rst_n = 1'b1;
    endtask

    task automatic run_program(input string name);
        int cycles;
        emit(enc_j(prog_len));
        run_model();
        apply_reset();
        cycles = 0;
        while (st_addr.size() < exp_addr.size() && cycles < 500) begin
            @(negedge clock);
            cycles++;
        end
        if (st_addr.size() < exp_addr.size()) begin
            timeouts++;
            $display("timeout: %s saw %0d of %0d stores", name, st_addr.size(), exp_addr.size());
        end
        // Late stores would show up as extra entries
        repeat (10) @(negedge clock);
        if (st_addr.size() != exp_addr.size()) begin
            mismatches++;
            $display("mismatch at %0t: %s made %0d stores, expected %0d",
                     $time, name, st_addr.size(), exp_addr.size());
        end
        for (int i = 0; i < st_addr.size() && i < exp_addr.size(); i++) begin
            if (st_addr[i] !== exp_addr[i] || st_data[i] !== exp_data[i]) begin
                mismatches++;
                $display("mismatch at %0t: %s store %0d got [%h]=%h, expected [%h]=%h", $time,
                         name, i, st_addr[i], st_data[i], exp_addr[i], exp_data[i]);
            end
        end
    endtask

    task automatic test_alu();
        new_program();
        emit(enc_i(OP_ADDI, 1, 0, int'(rand_bits(17))));
        emit(enc_i(OP_ADDI, 2, 0, int'(rand_bits(17))));
        emit(enc_i(OP_SW, 1, 0, 0));
        emit(enc_r(ALU_ADD, 3, 1, 2, 0));
        emit(enc_i(OP_SW, 3, 0, 1));
        emit(enc_r(ALU_SUB, 4, 1, 2, 0));
        emit(enc_i(OP_SW, 4, 0, 2));
        emit(enc_r(ALU_AND, 5, 1, 2, 0));
        emit(enc_i(OP_SW, 5, 0, 3));
        emit(enc_r(ALU_OR, 6, 1, 2, 0));
        emit(enc_i(OP_SW, 6, 0, 4));
        emit(enc_r(ALU_SLL, 7, 1, 0, int'(rand_bits(5))));
        emit(enc_i(OP_SW, 7, 0, 5));
        emit(enc_r(ALU_SRA, 8, 2, 0, int'(rand_bits(5))));
        emit(enc_i(OP_SW, 8, 0, 6));
        run_program("test_alu");
    endtask

    task automatic test_forward();
        new_program();
        emit(enc_i(OP_ADDI, 1, 0, 11));
        emit(enc_i(OP_ADDI, 2, 1, 3));
        emit(enc_i(OP_ADDI, 9, 0, 1));
        emit(enc_r(ALU_ADD, 3, 1, 2, 0));
        emit(enc_i(OP_ADDI, 10, 0, 2));
        emit(enc_i(OP_ADDI, 11, 0, 4));
        emit(enc_r(ALU_SUB, 4, 3, 1, 0));
        emit(enc_i(OP_SW, 4, 0, 0));
        emit(enc_i(OP_ADDI, 5, 4, 1));
        emit(enc_r(ALU_ADD, 6, 5, 5, 0));
        emit(enc_i(OP_ADDI, 7, 0, 20));
        emit(enc_i(OP_SW, 6, 7, 3));
        emit(enc_i(OP_SW, 2, 0, 2));
        run_program("test_forward");
    endtask

    task automatic test_load();
        new_program();
        emit(enc_i(OP_ADDI, 1, 0, 1234));
        emit(enc_i(OP_SW, 1, 0, 10));
        emit(enc_i(OP_LW, 2, 0, 10));
        emit(enc_i(OP_ADDI, 3, 2, 1));
        emit(enc_i(OP_SW, 3, 0, 11));
        emit(enc_i(OP_LW, 4, 0, 11));
        emit(enc_r(ALU_ADD, 5, 4, 4, 0));
        emit(enc_i(OP_SW, 5, 0, 12));
        emit(enc_i(OP_LW, 6, 0, 40));
        emit(enc_i(OP_SW, 6, 0, 13));
        run_program("test_load");
    endtask

    task automatic test_branch();
        int loop_pc;
        new_program();
        emit(enc_i(OP_ADDI, 1, 0, 5));
        emit(enc_i(OP_ADDI, 2, 0, -3));
        emit(enc_i(OP_ADDI, 9, 0, int'(MARK)));
        emit(enc_i(OP_BNE, 1, 2, 2));
        emit(enc_i(OP_SW, 9, 0, 30));
        emit(enc_i(OP_SW, 9, 0, 31));
        emit(enc_i(OP_SW, 1, 0, 20));
        emit(enc_i(OP_BNE, 1, 1, 2));
        emit(enc_i(OP_SW, 2, 0, 21));
        emit(enc_i(OP_BLT, 2, 1, 2));
        emit(enc_i(OP_SW, 9, 0, 32));
        emit(enc_i(OP_SW, 9, 0, 33));
        emit(enc_i(OP_SW, 2, 0, 22));
        emit(enc_i(OP_BLT, 1, 2, 2));
        emit(enc_i(OP_SW, 1, 0, 23));
        emit(enc_j(prog_len + 3));
        emit(enc_i(OP_SW, 9, 0, 34));
        emit(enc_i(OP_SW, 9, 0, 35));
        emit(enc_i(OP_SW, 2, 0, 24));
        // Counted loop with a backward branch
        emit(enc_i(OP_ADDI, 4, 0, 3));
        loop_pc = prog_len;
        emit(enc_i(OP_ADDI, 4, 4, -1));
        emit(enc_i(OP_SW, 4, 0, 26));
        emit(enc_i(OP_BNE, 4, 0, loop_pc - prog_len - 1));
        run_program("test_branch");
        foreach (st_data[i]) begin
            if (st_data[i] === MARK) begin
                mismatches++;
                $display("mismatch at %0t: shadow store %0d reached memory", $time, i);
            end
        end
    endtask

    task automatic test_zero();
        new_program();
        emit(enc_i(OP_ADDI, 0, 0, 77));
        emit(enc_i(OP_SW, 0, 0, 5));
        emit(enc_i(OP_ADDI, 1, 0, 9));
        emit(enc_r(ALU_ADD, 0, 1, 1, 0));
        emit(enc_i(OP_SW, 0, 0, 6));
        run_program("test_zero");
    endtask

    // Reset lands while a store sits in the memory stage
    task automatic test_reset();
        int cycles;
        new_program();
        emit(enc_i(OP_ADDI, 1, 0, 3));
        emit(enc_i(OP_SW, 1, 0, 7));
        emit(enc_j(1));
        apply_reset();
        cycles = 0;
        while (wren !== 1'b1 && cycles < 50) begin
            @(negedge clock);
            cycles++;
        end
        if (wren !== 1'b1) begin
            timeouts++;
            $display("timeout: test_reset saw no store before asserting reset");
        end
        apply_reset();
    endtask

    initial begin
        rst_n = 1'b0;
        new_program();
        test_alu();
        test_forward();
        test_load();
        test_branch();
        test_zero();
        test_reset();
        $display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* logic/pipeline_cpu.sv */
/*
 * Five-stage pipelined processor core
 * Fetch, decode, execute, memory and writeback, with forwarding and hazard control
 */
`timescale 1ns/100ps

module pipeline_cpu import cpu_pkg::*; (
    input  logic  clock,
    input  logic  rst_n,
    output word_t address_imem,
    input  word_t q_imem,
    output word_t address_dmem,
    output word_t data,
    output logic  wren,
    input  word_t q_dmem
);

    word_t        fd_pc, fd_ir;
    word_t        dx_pc, dx_ir, dx_a, dx_b;
    word_t        xm_ir, xm_result, xm_store_data;
    word_t        redirect_pc, wb_data;
    reg_addr_t    mw_rd, wb_addr;
    logic         stall, redirect, wb_en;
    forward_sel_e fwd_a, fwd_b;

    fetch_stage fetch_stage_inst (
        .clock (clock), .rst_n (rst_n), .stall (stall), .redirect (redirect),
        .redirect_pc (redirect_pc), .q_imem (q_imem), .address_imem (address_imem),
        .fd_pc (fd_pc), .fd_ir (fd_ir)
    );

    decode_stage decode_stage_inst (
        .clock (clock), .rst_n (rst_n), .stall (stall), .redirect (redirect),
        .fd_pc (fd_pc), .fd_ir (fd_ir), .wb_en (wb_en), .wb_addr (wb_addr),
        .wb_data (wb_data), .dx_pc (dx_pc), .dx_ir (dx_ir), .dx_a (dx_a), .dx_b (dx_b)
    );

    execute_stage execute_stage_inst (
        .clock (clock), .rst_n (rst_n), .dx_pc (dx_pc), .dx_ir (dx_ir),
        .dx_a (dx_a), .dx_b (dx_b), .fwd_a (fwd_a), .fwd_b (fwd_b),
        .wb_data (wb_data), .redirect (redirect), .redirect_pc (redirect_pc),
        .xm_ir (xm_ir), .xm_result (xm_result), .xm_store_data (xm_store_data)
    );

    hazard_unit hazard_unit_inst (
        .fd_ir (fd_ir), .dx_ir (dx_ir), .xm_ir (xm_ir), .mw_rd (mw_rd),
        .wb_en (wb_en), .fwd_a (fwd_a), .fwd_b (fwd_b), .stall (stall)
    );

    mem_wb_stage mem_wb_stage_inst (
        .clock (clock), .rst_n (rst_n), .xm_ir (xm_ir), .xm_result (xm_result),
        .xm_store_data (xm_store_data), .q_dmem (q_dmem),
        .address_dmem (address_dmem), .data (data), .wren (wren), .mw_rd (mw_rd),
        .wb_en (wb_en), .wb_addr (wb_addr), .wb_data (wb_data)
    );

endmodule

/* logic/mem_wb_stage.sv */
/*
 * Memory and writeback stages
 * Drives the data memory, holds the memory/writeback latch and produces
 * the register write
 */
`timescale 1ns/100ps
`include "cpu_params.svh"

module mem_wb_stage import cpu_pkg::*; (
    input  logic      clock,
    input  logic      rst_n,
    input  word_t     xm_ir,
    input  word_t     xm_result,
    input  word_t     xm_store_data,
    input  word_t     q_dmem,
    output word_t     address_dmem,
    output word_t     data,
    output logic      wren,
    output reg_addr_t mw_rd,
    output logic      wb_en,
    output reg_addr_t wb_addr,
    output word_t     wb_data
);

    word_t   mw_ir;
    word_t   mw_result;
    word_t   mw_load;
    opcode_e mw_op;

    assign address_dmem = xm_result;
    assign data         = xm_store_data;
    assign wren         = (xm_ir[`CPU_OPCODE_MSB:`CPU_OPCODE_LSB] == OP_SW);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            mw_ir     <= `CPU_NOP;
            mw_result <= '0;
            mw_load   <= '0;
        end else begin
            mw_ir     <= xm_ir;
            mw_result <= xm_result;
            mw_load   <= q_dmem;
        end
    end

    assign mw_op   = opcode_e'(mw_ir[`CPU_OPCODE_MSB:`CPU_OPCODE_LSB]);
    assign mw_rd   = mw_ir[`CPU_RD_LSB +: `CPU_REG_ADDR_W];
    assign wb_addr = mw_rd;
    assign wb_en   = (mw_op == OP_RTYPE) || (mw_op == OP_ADDI) || (mw_op == OP_LW);
    assign wb_data = (mw_op == OP_LW) ? mw_load : mw_result;

endmodule

/* logic/hazard_unit.sv */
/*
 * Hazard unit
 * Forward selects for the execute operands and the load-use stall
 */
`timescale 1ns/100ps
`include "cpu_params.svh"

module hazard_unit import cpu_pkg::*; (
    input  word_t        fd_ir,
    input  word_t        dx_ir,
    input  word_t        xm_ir,
    input  reg_addr_t    mw_rd,
    input  logic         wb_en,
    output forward_sel_e fwd_a,
    output forward_sel_e fwd_b,
    output logic         stall
);

    opcode_e   fd_op;
    opcode_e   dx_op;
    opcode_e   xm_op;
    reg_addr_t dx_rd;
    reg_addr_t xm_rd;
    logic      xm_writes;

    assign fd_op = opcode_e'(fd_ir[`CPU_OPCODE_MSB:`CPU_OPCODE_LSB]);
    assign dx_op = opcode_e'(dx_ir[`CPU_OPCODE_MSB:`CPU_OPCODE_LSB]);
    assign xm_op = opcode_e'(xm_ir[`CPU_OPCODE_MSB:`CPU_OPCODE_LSB]);
    assign dx_rd = dx_ir[`CPU_RD_LSB +: `CPU_REG_ADDR_W];
    assign xm_rd = xm_ir[`CPU_RD_LSB +: `CPU_REG_ADDR_W];

    // A load in the memory stage has no result yet, the stall covers it
    assign xm_writes = (xm_op == OP_RTYPE) || (xm_op == OP_ADDI);

    // Port B register, as decode reads it
    function automatic reg_addr_t b_reg(input word_t ir);
        if (ir[`CPU_OPCODE_MSB:`CPU_OPCODE_LSB] == OP_RTYPE) begin
            return ir[`CPU_RT_LSB +: `CPU_REG_ADDR_W];
        end
        return ir[`CPU_RD_LSB +: `CPU_REG_ADDR_W];
    endfunction

    function automatic forward_sel_e pick(input reg_addr_t src, input logic mem_hit_ok,
                                          input reg_addr_t mem_rd, input logic wb_ok,
                                          input reg_addr_t wb_rd);
        if (mem_hit_ok && mem_rd != '0 && mem_rd == src) begin
            return FWD_MEM;
        end
        if (wb_ok && wb_rd != '0 && wb_rd == src) begin
            return FWD_WB;
        end
        return FWD_NONE;
    endfunction

    assign fwd_a = pick(dx_ir[`CPU_RS_LSB +: `CPU_REG_ADDR_W], xm_writes, xm_rd, wb_en, mw_rd);
    assign fwd_b = pick(b_reg(dx_ir), xm_writes, xm_rd, wb_en, mw_rd);

    always_comb begin
        stall = 1'b0;
        if (dx_op == OP_LW && dx_rd != '0) begin
            if (fd_op != OP_J && fd_ir[`CPU_RS_LSB +: `CPU_REG_ADDR_W] == dx_rd) begin
                stall = 1'b1;
            end
            if (fd_op inside {OP_RTYPE, OP_SW, OP_BNE, OP_BLT} && b_reg(fd_ir) == dx_rd) begin
                stall = 1'b1;
            end
        end
    end

endmodule

/* logic/execute_stage.sv */
/*
 * Execute stage
 * Operand forwarding, ALU, branch and jump resolution, execute/memory latch
 */
`timescale 1ns/100ps
`include "cpu_params.svh"

module execute_stage import cpu_pkg::*; (
    input  logic         clock,
    input  logic         rst_n,
    input  word_t        dx_pc,
    input  word_t        dx_ir,
    input  word_t        dx_a,
    input  word_t        dx_b,
    input  forward_sel_e fwd_a,
    input  forward_sel_e fwd_b,
    input  word_t        wb_data,
    output logic         redirect,
    output word_t        redirect_pc,
    output word_t        xm_ir,
    output word_t        xm_result,
    output word_t        xm_store_data
);

    opcode_e                       opcode;
    alu_op_e                       alu_op;
    logic [$clog2(`CPU_XLEN)-1:0]  shamt;
    word_t                         imm;
    word_t                         jump_target;
    word_t                         op_a;
    word_t                         op_b;
    word_t                         alu_result;
    logic                          branch_taken;

    assign opcode = opcode_e'(dx_ir[`CPU_OPCODE_MSB:`CPU_OPCODE_LSB]);
    assign alu_op = alu_op_e'(dx_ir[`CPU_ALUOP_LSB +: $bits(alu_op_e)]);
    assign shamt  = dx_ir[`CPU_SHAMT_LSB +: $clog2(`CPU_XLEN)];
    assign imm    = {{(`CPU_XLEN - `CPU_IMM_W){dx_ir[`CPU_IMM_W-1]}}, dx_ir[`CPU_IMM_W-1:0]};
    assign jump_target = {{(`CPU_XLEN - `CPU_TARGET_W){1'b0}}, dx_ir[`CPU_TARGET_W-1:0]};

    // Memory stage result wins over writeback
    assign op_a = (fwd_a == FWD_MEM) ? xm_result :
                  (fwd_a == FWD_WB)  ? wb_data   : dx_a;
    assign op_b = (fwd_b == FWD_MEM) ? xm_result :
                  (fwd_b == FWD_WB)  ? wb_data   : dx_b;

    always_comb begin
        alu_result = op_a + imm;
        if (opcode == OP_RTYPE) begin
            case (alu_op)
                ALU_ADD: alu_result = op_a + op_b;
                ALU_SUB: alu_result = op_a - op_b;
                ALU_AND: alu_result = op_a & op_b;
                ALU_OR:  alu_result = op_a | op_b;
                ALU_SLL: alu_result = op_a << shamt;
                ALU_SRA: alu_result = word_t'($signed(op_a) >>> shamt);
                default: alu_result = '0;
            endcase
        end
    end

    // op_a holds rs, op_b holds rd for branches
    assign branch_taken = ((opcode == OP_BNE) && (op_b != op_a)) ||
                          ((opcode == OP_BLT) && ($signed(op_b) < $signed(op_a)));

    assign redirect    = branch_taken || (opcode == OP_J);
    assign redirect_pc = (opcode == OP_J) ? jump_target : dx_pc + word_t'(1) + imm;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            xm_ir         <= `CPU_NOP;
            xm_result     <= '0;
            xm_store_data <= '0;
        end else begin
            xm_ir         <= dx_ir;
            xm_result     <= alu_result;
            xm_store_data <= op_b;
        end
    end

endmodule

/* logic/decode_stage.sv */
/*
 * Decode stage
 * Reads the operands from the register file and fills the decode/execute
 * latch, or a bubble on stall or redirect
 */
`timescale 1ns/100ps
`include "cpu_params.svh"

module decode_stage import cpu_pkg::*; (
    input  logic      clock,
    input  logic      rst_n,
    input  logic      stall,
    input  logic      redirect,
    input  word_t     fd_pc,
    input  word_t     fd_ir,
    input  logic      wb_en,
    input  reg_addr_t wb_addr,
    input  word_t     wb_data,
    output word_t     dx_pc,
    output word_t     dx_ir,
    output word_t     dx_a,
    output word_t     dx_b
);

    opcode_e   opcode;
    reg_addr_t rs_addr;
    reg_addr_t b_addr;
    word_t     rs_data;
    word_t     b_data;

    assign opcode  = opcode_e'(fd_ir[`CPU_OPCODE_MSB:`CPU_OPCODE_LSB]);
    assign rs_addr = fd_ir[`CPU_RS_LSB +: `CPU_REG_ADDR_W];

    // Port B reads rt for R-type, rd for stores and branches
    assign b_addr = (opcode == OP_RTYPE) ? fd_ir[`CPU_RT_LSB +: `CPU_REG_ADDR_W]
                                         : fd_ir[`CPU_RD_LSB +: `CPU_REG_ADDR_W];

    reg_file reg_file_inst (
        .clock   (clock),
        .rst_n   (rst_n),
        .rs_addr (rs_addr),
        .rt_addr (b_addr),
        .rs_data (rs_data),
        .rt_data (b_data),
        .wb_en   (wb_en),
        .wb_addr (wb_addr),
        .wb_data (wb_data)
    );

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            dx_pc <= '0;
            dx_ir <= `CPU_NOP;
            dx_a  <= '0;
            dx_b  <= '0;
        end else if (stall || redirect) begin
            dx_pc <= '0;
            dx_ir <= `CPU_NOP;
            dx_a  <= '0;
            dx_b  <= '0;
        end else begin
            dx_pc <= fd_pc;
            dx_ir <= fd_ir;
            dx_a  <= rs_data;
            dx_b  <= b_data;
        end
    end

endmodule

/* logic/fetch_stage.sv */
/*
 * Fetch stage
 * Program counter and the fetch/decode latch, with stall and redirect
 */
`timescale 1ns/100ps
`include "cpu_params.svh"

module fetch_stage import cpu_pkg::*; (
    input  logic  clock,
    input  logic  rst_n,
    input  logic  stall,
    input  logic  redirect,
    input  word_t redirect_pc,
    input  word_t q_imem,
    output word_t address_imem,
    output word_t fd_pc,
    output word_t fd_ir
);

    word_t pc;

    assign address_imem = pc;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            pc    <= '0;
            fd_pc <= '0;
            fd_ir <= `CPU_NOP;
        end else if (redirect) begin
            // Taken branch or jump, drop the word fetched this cycle
            pc    <= redirect_pc;
            fd_pc <= '0;
            fd_ir <= `CPU_NOP;
        end else if (!stall) begin
            pc    <= pc + word_t'(1);
            fd_pc <= pc;
            fd_ir <= q_imem;
        end
    end

endmodule

/* logic/reg_file.sv */
/*
 * Register file, 32 x 32 bits, two read ports and one write port
 * Register 0 reads zero; a write is visible to reads in the same cycle
 */
`timescale 1ns/100ps
`include "cpu_params.svh"

module reg_file import cpu_pkg::*; (
    input  logic      clock,
    input  logic      rst_n,
    input  reg_addr_t rs_addr,
    input  reg_addr_t rt_addr,
    output word_t     rs_data,
    output word_t     rt_data,
    input  logic      wb_en,
    input  reg_addr_t wb_addr,
    input  word_t     wb_data
);

    word_t regs [`CPU_NUM_REGS];
    logic  wr_valid;

    assign wr_valid = wb_en && (wb_addr != '0);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `CPU_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_valid) begin
            regs[wb_addr] <= wb_data;
        end
    end

    // Pass the incoming write through to a matching read
    assign rs_data = (wr_valid && wb_addr == rs_addr) ? wb_data : regs[rs_addr];
    assign rt_data = (wr_valid && wb_addr == rt_addr) ? wb_data : regs[rt_addr];

endmodule

/* logic/cpu_pkg.sv */
/*
 * Processor core types
 * Data words, register indices, opcodes, ALU ops and forward selects
 */
`include "cpu_params.svh"

package cpu_pkg;

    typedef logic [`CPU_XLEN-1:0]       word_t;
    typedef logic [`CPU_REG_ADDR_W-1:0] reg_addr_t;

    typedef enum logic [4:0] {
        OP_RTYPE = 5'b00000,
        OP_J     = 5'b00001,
        OP_BNE   = 5'b00010,
        OP_ADDI  = 5'b00101,
        OP_BLT   = 5'b00110,
        OP_SW    = 5'b00111,
        OP_LW    = 5'b01000
    } opcode_e;

    typedef enum logic [4:0] {
        ALU_ADD = 5'd0,
        ALU_SUB = 5'd1,
        ALU_AND = 5'd2,
        ALU_OR  = 5'd3,
        ALU_SLL = 5'd4,
        ALU_SRA = 5'd5
    } alu_op_e;

    // Source of an execute operand
    typedef enum logic [1:0] {
        FWD_NONE = 2'd0,
        FWD_MEM  = 2'd1,
        FWD_WB   = 2'd2
    } forward_sel_e;

endpackage

/* logic/cpu_params.svh */
/*
 * Processor core parameters
 * Word and field widths, instruction field positions and the bubble word
 */
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

`define CPU_XLEN        32
`define CPU_REG_ADDR_W  5
`define CPU_NUM_REGS    32
`define CPU_IMM_W       17
`define CPU_TARGET_W    27

// Instruction field positions
`define CPU_OPCODE_MSB  31
`define CPU_OPCODE_LSB  27
`define CPU_RD_LSB      22
`define CPU_RS_LSB      17
`define CPU_RT_LSB      12
`define CPU_SHAMT_LSB   7
`define CPU_ALUOP_LSB   2

`define CPU_NOP         32'h0000_0000

`endif
